// ==== src/i2c_pkg.sv ====
// shared types for the i2c register target
// byte, device address and bit counter vectors, target FSM states

package i2c_pkg;

  //////////////////////////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////////////////////////

  typedef logic [7:0] byte_t;     // data byte, sub-address or shifter
  typedef logic [6:0] dev_addr_t; // 7-bit bus address
  typedef logic [3:0] bit_cnt_t;  // bits seen in a byte, 0..8

  //////////////////////////////////////////////////////////////////////
  // target FSM
  //////////////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    idle,       // waiting for a start
    addr_rise,  // address or sub-address bit, wait scl high
    addr_fall,  // same byte, wait scl low
    ack_phase,  // ack slot after address or sub-address
    wr_rise,    // write data bit, wait scl high
    wr_fall,    // write data bit, wait scl low
    wr_ack,     // ack slot after a stored byte
    rd_shift,   // driving read bits
    rd_ack      // host ack or nak slot
  } target_state_e;

endpackage

// ==== src/i2c_line_filter.sv ====
// SCL and SDA sampling with a three-sample glitch filter
// edge pulses, filtered SDA level, start and stop strobes

`timescale 1ns/1ps

module i2c_line_filter (
  input  logic clk,
  input  logic scl,
  input  logic sda_in,
  output logic scl_rise,
  output logic scl_fall,
  output logic sda_bit,
  output logic bus_start,
  output logic bus_stop
);

  // last line event codes
  localparam logic [1:0] ev_scl_rise = 2'd0;
  localparam logic [1:0] ev_scl_fall = 2'd1;
  localparam logic [1:0] ev_sda_rise = 2'd2;
  localparam logic [1:0] ev_sda_fall = 2'd3;

  logic [3:0] scl_r;      // bit 0 is the newest sample
  logic [3:0] sda_r;
  logic       sda_rise;
  logic       sda_fall;
  logic [1:0] last_event;

  always_ff @(posedge clk) begin
    scl_r <= {scl_r[2:0], scl};
    sda_r <= {sda_r[2:0], sda_in};
  end

  // edge = old level followed by three equal new samples
  assign scl_rise = (scl_r == 4'b0111);
  assign scl_fall = (scl_r == 4'b1000);
  assign sda_rise = (sda_r == 4'b0111);
  assign sda_fall = (sda_r == 4'b1000);

  // settled sda, holds while samples disagree
  always_ff @(posedge clk) begin
    if (sda_r[2:0] == 3'b111) begin
      sda_bit <= 1'b1;
    end else if (sda_r[2:0] == 3'b000) begin
      sda_bit <= 1'b0;
    end
  end

  // remember which line moved last
  always_ff @(posedge clk) begin
    if (scl_rise) begin
      last_event <= ev_scl_rise;
    end else if (scl_fall) begin
      last_event <= ev_scl_fall;
    end else if (sda_rise) begin
      last_event <= ev_sda_rise;
    end else if (sda_fall) begin
      last_event <= ev_sda_fall;
    end
  end

  // start: sda fell, then scl fell; stop: scl rose, then sda rose
  always_ff @(posedge clk) begin
    bus_start <= (last_event == ev_sda_fall) && scl_fall;
    bus_stop  <= (last_event == ev_scl_rise) && sda_rise;
  end

endmodule

// ==== src/i2c_target.sv ====
// i2c target protocol FSM
// address match and ack, sub-address capture, write and read byte shifting
// register address auto-increments per byte

`timescale 1ns/1ps

module i2c_target import i2c_pkg::*; #(
  parameter dev_addr_t dev_addr = 7'h70
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  scl_rise,
  input  logic  scl_fall,
  input  logic  sda_bit,
  input  logic  bus_start,
  input  logic  bus_stop,
  output logic  sda_pull,
  output byte_t reg_addr,
  output logic  wen,
  output byte_t wdata,
  input  byte_t rdata
);

  target_state_e state;
  byte_t         shift;     // in and out shifter
  bit_cnt_t      bit_cnt;
  logic          addr_seen; // device address taken since last start

  assign wdata = shift; // stable through the wen cycle

  ////////////////////////////////////////////////////////////////////////
  // protocol FSM
  ////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      state     <= idle;
      sda_pull  <= 1'b0;
      wen       <= 1'b0;
      reg_addr  <= '0;
      bit_cnt   <= '0;
      addr_seen <= 1'b0;
    end else if (bus_start || bus_stop) begin
      // any bus condition restarts the engine, reg_addr is kept
      state     <= bus_start ? addr_rise : idle;
      sda_pull  <= 1'b0;
      wen       <= 1'b0;
      bit_cnt   <= '0;
      addr_seen <= 1'b0;
    end else begin
      wen <= 1'b0; // single-cycle strobe
      if (wen) begin
        reg_addr <= reg_addr + 8'd1; // step after each stored byte
      end

      case (state)
        idle: begin
          sda_pull  <= 1'b0;
          bit_cnt   <= '0;
          addr_seen <= 1'b0;
        end

        // address byte, or sub-address once addr_seen
        addr_rise: begin
          if (scl_rise) begin
            shift   <= {shift[6:0], sda_bit};
            bit_cnt <= bit_cnt + 4'd1;
            state   <= addr_fall;
          end
        end

        addr_fall: begin
          if (scl_fall) begin
            if (bit_cnt < 4'd8) begin
              state <= addr_rise;
            end else if (!addr_seen && (shift[7:1] != dev_addr)) begin
              state <= idle; // someone else's address, stay off the line
            end else begin
              sda_pull <= 1'b1; // ack
              state    <= ack_phase;
            end
          end
        end

        ack_phase: begin
          if (scl_fall) begin
            sda_pull <= 1'b0;
            bit_cnt  <= '0;
            if (addr_seen) begin
              reg_addr <= shift; // sub-address
              state    <= wr_rise;
            end else if (shift[0]) begin
              // read: first byte out, msb on the line now
              shift    <= rdata;
              sda_pull <= ~rdata[7];
              reg_addr <= reg_addr + 8'd1;
              state    <= rd_shift;
            end else begin
              addr_seen <= 1'b1; // sub-address follows
              state     <= addr_rise;
            end
          end
        end

        //////////////////////////////////////////////////////////////////
        // write data
        //////////////////////////////////////////////////////////////////

        wr_rise: begin
          if (scl_rise) begin
            shift   <= {shift[6:0], sda_bit};
            bit_cnt <= bit_cnt + 4'd1;
            state   <= wr_fall;
          end
        end

        wr_fall: begin
          if (scl_fall) begin
            if (bit_cnt < 4'd8) begin
              state <= wr_rise;
            end else begin
              wen      <= 1'b1; // store the byte
              sda_pull <= 1'b1; // and ack it
              state    <= wr_ack;
            end
          end
        end

        wr_ack: begin
          if (scl_fall) begin
            sda_pull <= 1'b0;
            bit_cnt  <= '0;
            state    <= wr_rise;
          end
        end

        //////////////////////////////////////////////////////////////////
        // read data
        //////////////////////////////////////////////////////////////////

        rd_shift: begin
          if (scl_rise) begin
            bit_cnt <= bit_cnt + 4'd1;
          end
          if (scl_fall) begin
            if (bit_cnt < 4'd8) begin
              shift    <= {shift[6:0], 1'b0};
              sda_pull <= ~shift[6]; // next bit, pull only for a zero
            end else begin
              sda_pull <= 1'b0; // free the line for host ack
              state    <= rd_ack;
            end
          end
        end

        rd_ack: begin
          if (scl_rise && sda_bit) begin
            state <= idle; // host nak ends the burst
          end else if (scl_fall) begin
            shift    <= rdata;
            sda_pull <= ~rdata[7];
            reg_addr <= reg_addr + 8'd1;
            bit_cnt  <= '0;
            state    <= rd_shift;
          end
        end

        default: begin
          state <= idle;
        end
      endcase
    end
  end

endmodule

// ==== src/i2c_reg_bank.sv ====
// application register bank
// reg_count bytes, written on wen, read combinationally at reg_addr

`timescale 1ns/1ps

module i2c_reg_bank import i2c_pkg::*; #(
  parameter int reg_count = 16
) (
  input  logic  clk,
  input  logic  rst,
  input  logic  wen,
  input  byte_t reg_addr,
  input  byte_t wdata,
  output byte_t rdata
);

  localparam int idx_w = (reg_count > 1) ? $clog2(reg_count) : 1;

  byte_t            regs [reg_count];
  logic [idx_w-1:0] idx;

  // address wraps modulo the register count
  assign idx = idx_w'(reg_addr % reg_count);

  //////////////////////////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (wen) begin
      regs[idx] <= wdata;
    end
  end

  // same index for reads, target samples it on scl_fall
  assign rdata = regs[idx];

endmodule

// ==== src/i2c_reg_top.sv ====
// top level of the i2c register target
// line filter, protocol FSM and register bank

`timescale 1ns/1ps

module i2c_reg_top import i2c_pkg::*; #(
  parameter dev_addr_t dev_addr  = 7'h70,
  parameter int        reg_count = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic scl,      // resolved bus level
  input  logic sda_in,   // resolved bus level
  output logic sda_pull  // high pulls sda low
);

  logic  scl_rise;
  logic  scl_fall;
  logic  sda_bit;
  logic  bus_start;
  logic  bus_stop;
  byte_t reg_addr;
  logic  wen;
  byte_t wdata;
  byte_t rdata;

  i2c_line_filter u_filter (
    .clk       (clk),
    .scl       (scl),
    .sda_in    (sda_in),
    .scl_rise  (scl_rise),
    .scl_fall  (scl_fall),
    .sda_bit   (sda_bit),
    .bus_start (bus_start),
    .bus_stop  (bus_stop)
  );

  i2c_target #(.dev_addr(dev_addr)) u_target (
    .clk       (clk),
    .rst       (rst),
    .scl_rise  (scl_rise),
    .scl_fall  (scl_fall),
    .sda_bit   (sda_bit),
    .bus_start (bus_start),
    .bus_stop  (bus_stop),
    .sda_pull  (sda_pull),
    .reg_addr  (reg_addr),
    .wen       (wen),
    .wdata     (wdata),
    .rdata     (rdata)
  );

  i2c_reg_bank #(.reg_count(reg_count)) u_regs (
    .clk      (clk),
    .rst      (rst),
    .wen      (wen),
    .reg_addr (reg_addr),
    .wdata    (wdata),
    .rdata    (rdata)
  );

endmodule

// ==== dv/tb_clk_gen.sv ====
// clock and reset source for the testbench
// 40 ns clock, active-low reset held for 4 cycles

`timescale 1ns/1ps

module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk; // 40 ns period
  end

  initial begin
    rst = 1'b0;                // in reset from time zero
    repeat (4) @(negedge clk); // four rising edges see rst low
    rst = 1'b1;
  end

endmodule

// ==== dv/i2c_target_props.sv ====
// concurrent checks on the i2c target FSM
// sda pull after reset, single-cycle write strobe, no pull from idle

`timescale 1ns/1ps

module i2c_target_props import i2c_pkg::*; (
  input logic          clk,
  input logic          rst,
  input logic          sda_pull,
  input logic          wen,
  input target_state_e state
);

  //////////////////////////////////////////////////////////////////////
  // reset
  //////////////////////////////////////////////////////////////////////

  // line free in the cycle after any reset cycle
  pull_clear_after_reset: assert property (
    @(posedge clk) !rst |=> !sda_pull
  ) else $error("sda_pull is high in the cycle after reset");

  //////////////////////////////////////////////////////////////////////
  // running
  //////////////////////////////////////////////////////////////////////

  // store strobe lasts one clock
  wen_single_cycle: assert property (
    @(posedge clk) disable iff (!rst)
    wen |=> !wen
  ) else $error("wen stayed high for two cycles in a row");

  // pull only starts from an active state
  no_pull_in_idle: assert property (
    @(posedge clk) disable iff (!rst)
    $rose(sda_pull) |-> (state != idle)
  ) else $error("sda_pull rose while the target was idle");

endmodule

// ==== dv/i2c_tb.sv ====
// testbench for the i2c register target
// host bus model, 16-entry register model, test sequences, timeout

`timescale 1ns/1ps

module i2c_tb import i2c_pkg::*; ();

  localparam int    max_cycles = 20000;           // ~13k clocks of traffic plus margin
  localparam byte_t addr_wr    = {7'h70, 1'b0};
  localparam byte_t addr_rd    = {7'h70, 1'b1};
  localparam byte_t addr_other = {7'h71, 1'b0}; // nobody home

  logic  clk;
  logic  rst;
  logic  scl;
  logic  host_pull;  // host side of the open-drain sda
  logic  sda_pull;   // DUT side
  logic  sda;        // resolved line
  byte_t model [16]; // expected register contents
  int    seed      = 32'h0d4e_28d4;
  int    cycle_cnt = 0;

  assign sda = ~(host_pull | sda_pull); // low if either side pulls

  tb_clk_gen u_clk (
    .clk (clk),
    .rst (rst)
  );

  i2c_reg_top #(.dev_addr(7'h70), .reg_count(16)) DUT (
    .clk      (clk),
    .rst      (rst),
    .scl      (scl),
    .sda_in   (sda),
    .sda_pull (sda_pull)
  );

  bind i2c_target i2c_target_props u_props (
    .clk      (clk),
    .rst      (rst),
    .sda_pull (sda_pull),
    .wen      (wen),
    .state    (state)
  );

  //////////////////////////////////////////////////////////////////////
  // run control
  //////////////////////////////////////////////////////////////////////

  task automatic fail_stop(input string why);
    $display("%s", why);
    $display("TB FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  always @(posedge clk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt == max_cycles) begin
      fail_stop("timeout, the bus sequences did not finish within the cycle limit");
    end
  end

  task automatic wait_clks(input int n);
    repeat (n) @(negedge clk); // all driving on falling edges
  endtask

  //////////////////////////////////////////////////////////////////////
  // host bus model
  //////////////////////////////////////////////////////////////////////

  // one scl pulse, 8 clocks low then 8 high, line sampled mid-high
  task automatic clock_bit(input logic b, output logic seen);
    host_pull = ~b; // data changes only while scl low
    wait_clks(4);
    scl = 1'b1;
    wait_clks(4);
    seen = sda;
    wait_clks(4);
    scl = 1'b0;
    wait_clks(4);
  endtask

  // also serves as repeated start
  task automatic send_start();
    host_pull = 1'b0;
    wait_clks(4);
    scl = 1'b1;
    wait_clks(8);
    host_pull = 1'b1; // sda falls with scl high
    wait_clks(8);
    scl = 1'b0;
    wait_clks(4);
  endtask

  task automatic send_stop();
    host_pull = 1'b1; // sda low before scl rises
    wait_clks(4);
    scl = 1'b1;
    wait_clks(8);
    host_pull = 1'b0; // sda rises with scl high
    wait_clks(8);
  endtask

  task automatic write_byte(input byte_t d, output logic ack);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(d[i], seen); // msb first
    end
    clock_bit(1'b1, seen); // released for the target ack
    ack = ~seen;
  endtask

  task automatic read_byte(input logic nak, output byte_t d);
    logic seen;
    for (int i = 7; i >= 0; i--) begin
      clock_bit(1'b1, seen);
      d[i] = seen;
    end
    clock_bit(nak, seen); // host ack low, nak high
  endtask

  //////////////////////////////////////////////////////////////////////
  // checked transactions
  //////////////////////////////////////////////////////////////////////

  task automatic send_checked(input byte_t d, input logic want_ack, input string what);
    logic ack;
    write_byte(d, ack);
    assert (ack == want_ack) else
      fail_stop($sformatf("FAIL %0t: %s byte %02h got ack %0b, expected %0b",
                          $time, what, d, ack, want_ack));
  endtask

  task automatic write_regs(input byte_t sub, input int n);
    byte_t      d;
    logic [3:0] idx;
    send_start();
    send_checked(addr_wr, 1'b1, "address");
    send_checked(sub, 1'b1, "sub-address");
    for (int i = 0; i < n; i++) begin
      d   = byte_t'($random(seed));
      idx = 4'((sub + i) % 16); // wraps at the register count
      send_checked(d, 1'b1, "data");
      model[idx] = d;
    end
    send_stop();
  endtask

  // sub-address write, repeated start, burst read ended by a nak
  task automatic read_check(input byte_t sub, input int n);
    byte_t      d;
    logic [3:0] idx;
    send_start();
    send_checked(addr_wr, 1'b1, "address");
    send_checked(sub, 1'b1, "sub-address");
    send_start();
    send_checked(addr_rd, 1'b1, "read address");
    for (int i = 0; i < n; i++) begin
      idx = 4'((sub + i) % 16);
      read_byte(i == n - 1, d);
      assert (d == model[idx]) else
        fail_stop($sformatf("FAIL %0t: reg %0d read %02h, expected %02h",
                            $time, idx, d, model[idx]));
    end
    send_stop();
  endtask

  //////////////////////////////////////////////////////////////////////
  // test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    byte_t d;
    logic  seen;
    scl       = 1'b1; // bus idle
    host_pull = 1'b0;
    for (int i = 0; i < 16; i++) begin
      model[i] = '0;
    end
    wait (rst === 1'b1);
    wait_clks(8);

    read_check(8'd0, 16); // all clear out of reset

    write_regs(8'd3, 4); // burst write, read back
    read_check(8'd3, 4);

    send_start(); // foreign address, nothing acked or stored
    send_checked(addr_other, 1'b0, "foreign address");
    send_checked(8'd3, 1'b0, "foreign sub-address");
    send_checked(8'hA5, 1'b0, "foreign data");
    send_stop();
    read_check(8'd3, 4);

    write_regs(8'd14, 3); // 14, 15 then 0
    read_check(8'd14, 3);

    // stop after half a data byte
    write_regs(8'd8, 1);
    send_start();
    send_checked(addr_wr, 1'b1, "address");
    send_checked(8'd8, 1'b1, "sub-address");
    d = byte_t'($random(seed));
    for (int i = 7; i >= 4; i--) begin
      clock_bit(d[i], seen);
    end
    send_stop();
    read_check(8'd8, 1); // old value kept
    write_regs(8'd8, 2);
    read_check(8'd7, 3);

    read_check(8'd0, 5); // nak then stop
    assert (sda === 1'b1 && sda_pull === 1'b0) else
      fail_stop($sformatf("FAIL %0t: sda still pulled after nak and stop", $time));
    read_check(8'd10, 2); // starts at its own sub-address

    $display("TB PASSED");
    $finish;
  end

endmodule

// ==== flist.f ====
src/i2c_pkg.sv
src/i2c_line_filter.sv
src/i2c_target.sv
src/i2c_reg_bank.sv
src/i2c_reg_top.sv
dv/tb_clk_gen.sv
dv/i2c_target_props.sv
dv/i2c_tb.sv

// ==== Makefile ====
# Verilator build and run for the i2c register target testbench

TOP := i2c_tb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build $(TOP) with Verilator, run it, fail unless the pass line is printed"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --timing --timescale 1ns/1ps \
	  --top-module $(TOP) -f flist.f -o sim
	@out="$$(./obj_dir/sim)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TB PASSED"

clean:
	rm -rf obj_dir
